/* hdl/basket_pkg.sv */
/* Shared widths, types and constants of the basket controller.
   All price arithmetic wraps modulo 2^PRICE_W; count_t caps the basket at 15 slots. */
`default_nettype none

package basket_pkg;

	localparam int ID_W    = 4;
	localparam int QTT_W   = 4;
	localparam int PRICE_W = 16;
	localparam int COUNT_W = 4;

	typedef logic [ID_W-1:0]    product_id_t;
	typedef logic [QTT_W-1:0]   qty_t;
	typedef logic [PRICE_W-1:0] price_t;
	typedef logic [COUNT_W-1:0] count_t;

	// Products 0 to 14 are real, ID 15 marks an unused slot
	localparam int NUM_PRODUCTS = 15;

	localparam product_id_t EMPTY_ID    = product_id_t'(15);
	localparam qty_t        EMPTY_QTY   = '1;
	localparam price_t      EMPTY_PRICE = '1;

	// Unit price of product n is 10*(n+1) after reset
	localparam price_t DEFAULT_UNIT_PRICE [NUM_PRODUCTS] = '{
		16'd10,  16'd20,  16'd30,
		16'd40,  16'd50,  16'd60,
		16'd70,  16'd80,  16'd90,
		16'd100, 16'd110, 16'd120,
		16'd130, 16'd140, 16'd150
	};

	// Operation taken by the basket in one cycle
	typedef enum logic [1:0] {
		OP_NONE,
		OP_ADD,
		OP_CANCEL
	} basket_op_e;

endpackage

`default_nettype wire

/* hdl/price_table.sv */
/* Unit-price registers, one per product, loaded with the defaults at reset.
   Writes to ID 15 are dropped; line_price is combinational and reads 0 for ID 15. */
`timescale 1ns/1ps
`default_nettype none

module price_table (
	input  logic                   CLK,
	input  logic                   RESET_N,

	input  logic                   price_wr,
	input  basket_pkg::product_id_t price_wr_id,
	input  basket_pkg::price_t     price_wr_value,

	input  basket_pkg::product_id_t lookup_id,
	input  basket_pkg::qty_t       lookup_qty,
	output basket_pkg::price_t     line_price
);

	import basket_pkg::*;

	price_t unit_price [NUM_PRODUCTS];
	price_t unit_sel;

	// Single write per cycle, new value seen from the next cycle on
	always_ff @(posedge CLK) begin
		if (!RESET_N) begin
			for (int i = 0; i < NUM_PRODUCTS; i++) begin
				unit_price[i] <= DEFAULT_UNIT_PRICE[i];
			end
		end else begin
			for (int i = 0; i < NUM_PRODUCTS; i++) begin
				if (price_wr && price_wr_id == product_id_t'(i)) begin
					unit_price[i] <= price_wr_value;
				end
			end
		end
	end

	// No entry matches ID 15, so the select stays 0
	always_comb begin
		unit_sel = '0;
		for (int i = 0; i < NUM_PRODUCTS; i++) begin
			if (lookup_id == product_id_t'(i)) begin
				unit_sel = unit_price[i];
			end
		end
	end

	// Product truncated to the price width
	assign line_price = price_t'(unit_sel * price_t'(lookup_qty));

endmodule

`default_nettype wire

/* hdl/basket_list.sv */
/* Basket storage with append at the tail and cancel with shift toward the head.
   MAX_ITEMS must be 1 to 15; cancel beats add in the same cycle, rejected ops are dropped. */
`timescale 1ns/1ps
`default_nettype none

module basket_list #(
	parameter int unsigned MAX_ITEMS = 12
) (
	input  logic                    CLK,
	input  logic                    RESET_N,

	input  logic                    add,
	input  basket_pkg::product_id_t add_id,
	input  basket_pkg::qty_t        add_qty,
	input  basket_pkg::price_t      line_price,

	input  logic                    cancel,
	input  basket_pkg::count_t      cancel_slot,

	output basket_pkg::count_t      num,
	output basket_pkg::price_t      total,
	output basket_pkg::product_id_t entry_id    [MAX_ITEMS],
	output basket_pkg::qty_t        entry_qty   [MAX_ITEMS],
	output basket_pkg::price_t      entry_price [MAX_ITEMS]
);

	import basket_pkg::*;

	basket_op_e  op;
	logic        full;
	price_t      removed_price;

	product_id_t id_d    [MAX_ITEMS];
	qty_t        qty_d   [MAX_ITEMS];
	price_t      price_d [MAX_ITEMS];
	count_t      num_d;
	price_t      total_d;

	assign full = (num >= count_t'(MAX_ITEMS));

	// A high cancel always blocks the add, even when the slot is out of range
	always_comb begin
		op = OP_NONE;
		if (cancel) begin
			if (cancel_slot < num) begin
				op = OP_CANCEL;
			end
		end else if (add && !full) begin
			op = OP_ADD;
		end
	end

	// Price of the slot leaving the basket this cycle
	always_comb begin
		removed_price = '0;
		for (int i = 0; i < MAX_ITEMS; i++) begin
			if (cancel_slot == count_t'(i)) begin
				removed_price = entry_price[i];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < MAX_ITEMS; i++) begin
			id_d[i]    = entry_id[i];
			qty_d[i]   = entry_qty[i];
			price_d[i] = entry_price[i];
		end
		num_d   = num;
		total_d = total;

		case (op)
			OP_ADD: begin
				for (int i = 0; i < MAX_ITEMS; i++) begin
					if (num == count_t'(i)) begin
						id_d[i]    = add_id;
						qty_d[i]   = add_qty;
						price_d[i] = line_price;
					end
				end
				total_d = total + line_price;
				num_d   = num + count_t'(1);
			end

			OP_CANCEL: begin
				// Slots from the cancelled one upward take their upper neighbour
				for (int i = 0; i < MAX_ITEMS - 1; i++) begin
					if (count_t'(i) >= cancel_slot) begin
						id_d[i]    = entry_id[i+1];
						qty_d[i]   = entry_qty[i+1];
						price_d[i] = entry_price[i+1];
					end
				end
				// Last slot is always free after a cancel
				id_d[MAX_ITEMS-1]    = EMPTY_ID;
				qty_d[MAX_ITEMS-1]   = EMPTY_QTY;
				price_d[MAX_ITEMS-1] = EMPTY_PRICE;
				total_d = total - removed_price;
				num_d   = num - count_t'(1);
			end

			default: begin
			end
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RESET_N) begin
			num   <= '0;
			total <= '0;
			for (int i = 0; i < MAX_ITEMS; i++) begin
				entry_id[i]    <= EMPTY_ID;
				entry_qty[i]   <= EMPTY_QTY;
				entry_price[i] <= EMPTY_PRICE;
			end
		end else begin
			num   <= num_d;
			total <= total_d;
			for (int i = 0; i < MAX_ITEMS; i++) begin
				entry_id[i]    <= id_d[i];
				entry_qty[i]   <= qty_d[i];
				entry_price[i] <= price_d[i];
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/basket_top.sv */
/* Basket controller top: price table beside the basket list.
   All controls are single-cycle strobes sampled at the rising edge of CLK. */
`timescale 1ns/1ps
`default_nettype none

module basket_top #(
	parameter int unsigned MAX_ITEMS = 12
) (
	input  logic                    CLK,
	input  logic                    RESET_N,

	input  logic                    add,
	input  basket_pkg::product_id_t add_id,
	input  basket_pkg::qty_t        add_qty,

	input  logic                    cancel,
	input  basket_pkg::count_t      cancel_slot,

	input  logic                    price_wr,
	input  basket_pkg::product_id_t price_wr_id,
	input  basket_pkg::price_t      price_wr_value,

	output basket_pkg::count_t      num,
	output basket_pkg::price_t      total,
	output basket_pkg::product_id_t entry_id    [MAX_ITEMS],
	output basket_pkg::qty_t        entry_qty   [MAX_ITEMS],
	output basket_pkg::price_t      entry_price [MAX_ITEMS]
);

	import basket_pkg::*;

	price_t line_price;

	// Lookup follows the add inputs, so an add sees the price before a same-cycle write
	price_table price_table_i (
		.CLK            (CLK),
		.RESET_N        (RESET_N),
		.price_wr       (price_wr),
		.price_wr_id    (price_wr_id),
		.price_wr_value (price_wr_value),
		.lookup_id      (add_id),
		.lookup_qty     (add_qty),
		.line_price     (line_price)
	);

	basket_list #(
		.MAX_ITEMS (MAX_ITEMS)
	) basket_list_i (
		.CLK         (CLK),
		.RESET_N     (RESET_N),
		.add         (add),
		.add_id      (add_id),
		.add_qty     (add_qty),
		.line_price  (line_price),
		.cancel      (cancel),
		.cancel_slot (cancel_slot),
		.num         (num),
		.total       (total),
		.entry_id    (entry_id),
		.entry_qty   (entry_qty),
		.entry_price (entry_price)
	);

endmodule

`default_nettype wire

/* tb/basket_sva.sv */
/* Concurrent checks on basket_list, bound from the testbench.
   Checks are off while RESET_N is low. */
`timescale 1ns/1ps
`default_nettype none

module basket_sva #(
	parameter int unsigned MAX_ITEMS = 12
) (
	input logic               CLK,
	input logic               RESET_N,
	input logic               add,
	input logic               cancel,
	input basket_pkg::count_t cancel_slot,
	input basket_pkg::count_t num,
	input basket_pkg::price_t total
);

	import basket_pkg::*;

	logic valid_add;
	logic valid_cancel;

	// Cancel strobe blocks the add whether or not its slot is valid
	assign valid_add    = add && !cancel && (num < count_t'(MAX_ITEMS));
	assign valid_cancel = cancel && (cancel_slot < num);

	num_in_range: assert property (
		@(posedge CLK) disable iff (!RESET_N)
		num <= count_t'(MAX_ITEMS)
	) else $error("basket count above MAX_ITEMS");

	total_held: assert property (
		@(posedge CLK) disable iff (!RESET_N)
		!(valid_add || valid_cancel) |=> $stable(total)
	) else $error("total moved in a cycle without a valid operation");

	add_counts: assert property (
		@(posedge CLK) disable iff (!RESET_N)
		valid_add |=> num == $past(num) + count_t'(1)
	) else $error("valid add did not raise the count by one");

	cancel_counts: assert property (
		@(posedge CLK) disable iff (!RESET_N)
		valid_cancel |=> num == $past(num) - count_t'(1)
	) else $error("valid cancel did not lower the count by one");

endmodule

`default_nettype wire

/* tb/basket_tb.sv */
/* Testbench for basket_top, driven record by record from tb/basket_stimulus.txt.
   Run from the project root; stops at the first mismatch. */
`timescale 1ns/1ps
`default_nettype none

module basket_tb;

	import basket_pkg::*;

	localparam int unsigned MAX_ITEMS    = 12;
	localparam int          RESET_CYCLES = 16;
	localparam int          MAX_RECORDS  = 256;
	localparam int          LINE_LIMIT   = 512;

	logic        CLK;
	logic        RESET_N;
	logic        add;
	product_id_t add_id;
	qty_t        add_qty;
	logic        cancel;
	count_t      cancel_slot;
	logic        price_wr;
	product_id_t price_wr_id;
	price_t      price_wr_value;

	count_t      num;
	price_t      total;
	product_id_t entry_id    [MAX_ITEMS];
	qty_t        entry_qty   [MAX_ITEMS];
	price_t      entry_price [MAX_ITEMS];

	integer      seed;

	basket_top #(
		.MAX_ITEMS (MAX_ITEMS)
	) basket_top_i (
		.CLK            (CLK),
		.RESET_N        (RESET_N),
		.add            (add),
		.add_id         (add_id),
		.add_qty        (add_qty),
		.cancel         (cancel),
		.cancel_slot    (cancel_slot),
		.price_wr       (price_wr),
		.price_wr_id    (price_wr_id),
		.price_wr_value (price_wr_value),
		.num            (num),
		.total          (total),
		.entry_id       (entry_id),
		.entry_qty      (entry_qty),
		.entry_price    (entry_price)
	);

	bind basket_list basket_sva #(
		.MAX_ITEMS (MAX_ITEMS)
	) basket_sva_i (
		.CLK         (CLK),
		.RESET_N     (RESET_N),
		.add         (add),
		.cancel      (cancel),
		.cancel_slot (cancel_slot),
		.num         (num),
		.total       (total)
	);

	initial begin
		CLK = 1'b0;
		forever begin
			#2 CLK = ~CLK;
		end
	end

	task automatic stop_with_failure(input string what);
		$display("%s", what);
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		assert (actual == expected) else begin
			stop_with_failure($sformatf("** Error at time %0t: %s expected %0d, got %0d",
				$realtime, name, expected, actual));
		end
	endtask

	task automatic clear_strobes();
		add            = 1'b0;
		add_id         = '0;
		add_qty        = '0;
		cancel         = 1'b0;
		cancel_slot    = '0;
		price_wr       = 1'b0;
		price_wr_id    = '0;
		price_wr_value = '0;
	endtask

	task automatic drive_op(input basket_op_e op, input int id, input int qty, input int slot);
		case (op)
			OP_ADD: begin
				add     = 1'b1;
				add_id  = product_id_t'(id);
				add_qty = qty_t'(qty);
			end
			OP_CANCEL: begin
				cancel      = 1'b1;
				cancel_slot = count_t'(slot);
			end
			default: begin
			end
		endcase
	endtask

	task automatic drive_write(input int id, input int value);
		price_wr       = 1'b1;
		price_wr_id    = product_id_t'(id);
		price_wr_value = price_t'(value);
	endtask

	// Called 1 ns after an edge with inputs set; checks 0.5 ns after the next edge
	task automatic apply_cycle(input int exp_num, input int exp_total);
		@(posedge CLK);
		#0.5;
		check_value("num", exp_num, int'(num));
		check_value("total", exp_total, int'(total));
		#0.5;
		clear_strobes();
	endtask

	task automatic idle_stretch(input int exp_num, input int exp_total);
		int     length;
		int     cycles;
		price_t start_total;
		length      = 1 + int'($unsigned($random(seed)) % 6);
		start_total = total;
		cycles      = 0;
		while (cycles < length) begin
			@(posedge CLK);
			#0.5;
			check_value("total across idle", int'(start_total), int'(total));
			check_value("num", exp_num, int'(num));
			check_value("total", exp_total, int'(total));
			#0.5;
			cycles++;
		end
	endtask

	task automatic check_slot(input int slot, input int id, input int qty, input int price);
		assert (slot >= 0 && slot < int'(MAX_ITEMS)) else begin
			stop_with_failure($sformatf("Stimulus names slot %0d, outside the basket", slot));
		end
		check_value($sformatf("entry_id[%0d]", slot), id, int'(entry_id[slot]));
		check_value($sformatf("entry_qty[%0d]", slot), qty, int'(entry_qty[slot]));
		check_value($sformatf("entry_price[%0d]", slot), price, int'(entry_price[slot]));
	endtask

	task automatic skip_line(input int fd);
		int ch;
		int guard;
		ch    = 0;
		guard = 0;
		while (ch != 10 && ch != -1) begin
			assert (guard < LINE_LIMIT) else begin
				stop_with_failure("Comment line in the stimulus file is too long");
			end
			ch = $fgetc(fd);
			guard++;
		end
	endtask

	task automatic expect_fields(input int got, input int wanted);
		assert (got == wanted) else begin
			stop_with_failure("Stimulus record has missing or unreadable fields");
		end
	endtask

	task automatic run_record(input int fd, input logic [63:0] kind);
		int v0;
		int v1;
		int v2;
		int v3;
		int v4;
		int v5;
		int got;
		if (kind == "#") begin
			skip_line(fd);
		end else if (kind == "add") begin
			got = $fscanf(fd, "%d %d %d %d", v0, v1, v2, v3);
			expect_fields(got, 4);
			drive_op(OP_ADD, v0, v1, 0);
			apply_cycle(v2, v3);
		end else if (kind == "cancel") begin
			got = $fscanf(fd, "%d %d %d", v0, v1, v2);
			expect_fields(got, 3);
			drive_op(OP_CANCEL, 0, 0, v0);
			apply_cycle(v1, v2);
		end else if (kind == "write") begin
			got = $fscanf(fd, "%d %d %d %d", v0, v1, v2, v3);
			expect_fields(got, 4);
			drive_write(v0, v1);
			apply_cycle(v2, v3);
		end else if (kind == "addwr") begin
			got = $fscanf(fd, "%d %d %d %d %d %d", v0, v1, v2, v3, v4, v5);
			expect_fields(got, 6);
			drive_op(OP_ADD, v0, v1, 0);
			drive_write(v2, v3);
			apply_cycle(v4, v5);
		end else if (kind == "both") begin
			got = $fscanf(fd, "%d %d %d %d %d", v0, v1, v2, v3, v4);
			expect_fields(got, 5);
			drive_op(OP_ADD, v0, v1, 0);
			drive_op(OP_CANCEL, 0, 0, v2);
			apply_cycle(v3, v4);
		end else if (kind == "idle") begin
			got = $fscanf(fd, "%d %d", v0, v1);
			expect_fields(got, 2);
			idle_stretch(v0, v1);
		end else if (kind == "slot") begin
			got = $fscanf(fd, "%d %d %d %d", v0, v1, v2, v3);
			expect_fields(got, 4);
			check_slot(v0, v1, v2, v3);
		end else begin
			stop_with_failure("Unknown record kind in the stimulus file");
		end
	endtask

	initial begin
		#10000;
		stop_with_failure("Timeout: the run did not finish in time");
	end

	initial begin
		int          fd;
		int          got;
		int          records;
		logic [63:0] kind;
		seed     = 50;
		RESET_N  = 1'b0;
		clear_strobes();
		fd = $fopen("tb/basket_stimulus.txt", "r");
		assert (fd != 0) else begin
			stop_with_failure("Cannot open tb/basket_stimulus.txt");
		end

		repeat (RESET_CYCLES) @(posedge CLK);
		#1;
		RESET_N = 1'b1;

		records = 0;
		got     = $fscanf(fd, "%s", kind);
		while (got == 1) begin
			assert (records < MAX_RECORDS) else begin
				stop_with_failure("Stimulus file holds more records than allowed");
			end
			records++;
			run_record(fd, kind);
			got = $fscanf(fd, "%s", kind);
		end
		$fclose(fd);

		if (records > 0) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			stop_with_failure("No records were run from the stimulus file");
		end
	end

endmodule

`default_nettype wire

/* tb/basket_stimulus.txt */
# Decimal fields; n and t are the expected num and total after the edge
# add id qty n t | cancel slot n t | write id val n t | addwr id qty wid wval n t | both id qty slot n t | idle n t | slot s id qty price
idle 0 0
slot 0 15 15 65535
slot 1 15 15 65535
slot 2 15 15 65535
slot 3 15 15 65535
slot 4 15 15 65535
slot 5 15 15 65535
slot 6 15 15 65535
slot 7 15 15 65535
slot 8 15 15 65535
slot 9 15 15 65535
slot 10 15 15 65535
slot 11 15 15 65535
# Three adds at default prices
add 2 3 1 90
add 5 1 2 150
add 0 4 3 190
slot 0 2 3 90
slot 1 5 1 60
slot 2 0 4 40
slot 3 15 15 65535
# Cancel the middle slot
cancel 1 2 130
slot 0 2 3 90
slot 1 0 4 40
slot 2 15 15 65535
# Price writes, then an add in the same cycle as a write
write 7 200 2 130
add 7 2 3 530
slot 2 7 2 400
addwr 3 2 3 55 4 610
slot 3 3 2 80
add 3 1 5 665
slot 4 3 1 55
idle 5 665
# Fill to twelve, then one add too many
add 0 1 6 675
add 1 1 7 695
add 4 2 8 795
add 6 1 9 865
add 8 1 10 955
add 9 1 11 1055
add 14 2 12 1355
slot 11 14 2 300
add 10 5 12 1355
slot 11 14 2 300
# Out of range cancels, then the head slot
cancel 12 12 1355
cancel 15 12 1355
cancel 0 11 1265
slot 0 0 4 40
slot 10 14 2 300
slot 11 15 15 65535
cancel 11 11 1265
# Add and cancel in one cycle
both 1 3 2 10 1185
slot 2 3 1 55
slot 9 14 2 300
slot 10 15 15 65535
both 2 1 13 10 1185
add 1 3 11 1245
slot 10 1 3 60
idle 11 1245

/* vlog.f */
hdl/basket_pkg.sv
hdl/price_table.sv
hdl/basket_list.sv
hdl/basket_top.sv
tb/basket_sva.sv
tb/basket_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the basket testbench with Verilator; exit status gives the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f vlog.f --top-module basket_tb -o basket_sim &&
./obj_dir/basket_sim || {
	echo "basket simulation failed"
	exit 1
}
